//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcs_subsystem \
    -f sources.f \
    -o tb_dcs_subsystem

./obj_dir/tb_dcs_subsystem > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result, see $LOG"
    exit 1
fi

echo "simulation passed"

//--- sources.f
verilog/dcs_pkg.sv
verilog/dcs_cmd_if.sv
verilog/dcs_byte_fifo.sv
verilog/dcs_cmd_parser.sv
verilog/dcs_reg_bank.sv
verilog/dcs_subsystem_top.sv
verif/dcs_assertions.sv
verif/tb_dcs_subsystem.sv

//--- verif/dcs_assertions.sv
// Top-level handshake assertions
`timescale 1ns/1ps
`default_nettype none

module dcs_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       upd_valid,
    input logic       upd_ready,
    input logic [7:0] upd_opcode,
    input logic [7:0] unknown_count
);

    // stalled update keeps its record
    property upd_held;
        @(posedge clk) disable iff (!rst_n)
            upd_valid && !upd_ready |=> upd_valid && $stable(upd_opcode);
    endproperty

    upd_held_a: assert property (upd_held)
        else $error("upd_valid or upd_opcode changed while the panel stalled");

    upd_quiet_a: assert property (@(posedge clk) $rose(rst_n) |-> !upd_valid)
        else $error("upd_valid high in the first cycle after reset");

    unknown_mono_a: assert property (
        @(posedge clk) disable iff (!rst_n) unknown_count >= $past(unknown_count)
    ) else $error("unknown_count decreased");

endmodule

bind dcs_subsystem_top dcs_assertions u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .upd_valid     (upd_valid),
    .upd_ready     (upd_ready),
    .upd_opcode    (upd_opcode),
    .unknown_count (unknown_count)
);

`default_nettype wire

//--- verif/tb_dcs_subsystem.sv
// Display command subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dcs_subsystem;

    localparam int HALF_PERIOD = 50;

    logic                 clk;
    logic                 rst_n;
    logic [7:0]           rx_data;
    logic                 rx_valid;
    logic                 rx_ready;
    logic                 upd_valid;
    logic                 upd_ready;
    dcs_pkg::dcs_opcode_e upd_opcode;
    logic [15:0]          brightness;
    logic [7:0]           pixel_format;
    logic [23:0]          window;
    logic [7:0]           unknown_count;

    // expected updates, {opcode, brightness, pixel_format, window}
    logic [55:0] exp_q[$];
    logic [7:0]  stim_q[$];
    logic [47:0] model_regs = '0;
    int          model_unknown = 0;
    int          total_bytes = 0;
    int          cycles = 0;
    logic        bp_mode = 1'b0;
    string       cur_test = "reset";

    dcs_subsystem_top #(
        .FIFO_DEPTH (8)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .upd_valid     (upd_valid),
        .upd_ready     (upd_ready),
        .upd_opcode    (upd_opcode),
        .brightness    (brightness),
        .pixel_format  (pixel_format),
        .window        (window),
        .unknown_count (unknown_count)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED test=%s %s expected=0x%0h actual=0x%0h",
                     cur_test, what, expected, actual);
            abort_run();
        end
    endtask

    // parameter bytes per opcode
    function automatic int param_len(input logic [7:0] op);
        case (op)
            8'h01:   return 2;
            8'h02:   return 1;
            8'h03:   return 3;
            default: return 0;
        endcase
    endfunction

    // reference model, regs = {brightness, pixel_format, window}
    function automatic logic [47:0] apply_cmd(input logic [47:0] regs,
                                              input logic [7:0] op,
                                              input logic [23:0] params);
        logic [47:0] nxt;
        nxt = regs;
        case (op)
            8'h01:   nxt[47:32] = params[15:0];
            8'h02:   nxt[31:24] = params[7:0];
            8'h03:   nxt[23:0] = params;
            8'h04:   nxt = '0;
            default: nxt = regs;
        endcase
        return nxt;
    endfunction

    task automatic push_byte(input logic [7:0] b);
        stim_q.push_back(b);
        total_bytes++;
    endtask

    task automatic add_cmd(input logic [7:0] op, input logic [23:0] params);
        logic [23:0] used;
        int          i;
        used = '0;
        push_byte(op);
        // most significant parameter byte first
        for (i = param_len(op) - 1; i >= 0; i--) begin
            push_byte(params[8*i +: 8]);
            used = {used[15:0], params[8*i +: 8]};
        end
        model_regs = apply_cmd(model_regs, op, used);
        exp_q.push_back({op, model_regs});
    endtask

    task automatic add_unknown();
        logic [7:0] b;
        do begin
            b = 8'($urandom);
        end while (b >= 8'h01 && b <= 8'h04);
        push_byte(b);
        if (model_unknown < 255) begin
            model_unknown++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input int max_gap);
        int gap;
        gap = $urandom_range(max_gap);
        repeat (gap) begin
            rx_valid <= 1'b0;
            @(posedge clk);
        end
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(negedge clk);
        while (!rx_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_list(input int max_gap);
        while (stim_q.size() != 0) begin
            send_byte(stim_q.pop_front(), max_gap);
        end
        rx_valid <= 1'b0;
    endtask

    task automatic wait_updates_done();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_value("unknown_count", 32'(model_unknown), 32'(unknown_count));
        @(posedge clk);
    endtask

    initial begin
        int lat;
        int i;
        rst_n     = 1'b0;
        rx_data   = '0;
        rx_valid  = 1'b0;
        upd_ready = 1'b1;
        void'($urandom(32'hab79));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("rx_ready", 32'd1, 32'(rx_ready));
        check_value("upd_valid", 32'd0, 32'(upd_valid));
        check_value("brightness", 32'd0, 32'(brightness));
        check_value("pixel_format", 32'd0, 32'(pixel_format));
        check_value("window", 32'd0, 32'(window));
        check_value("unknown_count", 32'd0, 32'(unknown_count));
        @(posedge clk);

        // one command at a time, idle pipeline
        cur_test = "each_opcode";
        for (i = 1; i <= 4; i++) begin
            add_cmd(8'(i), 24'($urandom));
            send_list(0);
            lat = 1;
            @(negedge clk);
            while (!upd_valid) begin
                @(posedge clk);
                lat++;
                @(negedge clk);
            end
            check_value("update latency", 32'd3, 32'(lat));
            wait_updates_done();
        end

        cur_test = "soft_reset";
        add_cmd(8'h01, 24'($urandom) | 24'h000101);
        add_cmd(8'h02, 24'($urandom) | 24'h000001);
        add_cmd(8'h03, 24'($urandom) | 24'h010101);
        add_cmd(8'h04, 24'h0);
        send_list(1);
        wait_updates_done();

        cur_test = "unknown_between";
        for (i = 0; i < 6; i++) begin
            add_cmd(8'($urandom_range(4, 1)), 24'($urandom));
            add_unknown();
            add_unknown();
        end
        add_cmd(8'h03, 24'($urandom));
        send_list(2);
        wait_updates_done();

        cur_test = "back_pressure";
        bp_mode = 1'b1;
        for (i = 0; i < 200; i++) begin
            if ($urandom_range(9) == 0) begin
                add_unknown();
            end
            add_cmd(8'($urandom_range(4, 1)), 24'($urandom));
        end
        send_list(3);
        wait_updates_done();
        bp_mode = 1'b0;

        // enough dropped bytes to pin the counter at 255
        cur_test = "unknown_saturate";
        for (i = 0; i < 9; i++) begin
            add_cmd(8'($urandom_range(4, 1)), 24'($urandom));
            repeat (30) add_unknown();
        end
        add_cmd(8'h01, 24'($urandom));
        send_list(0);
        wait_updates_done();

        $display("TB PASSED");
        $finish;
    end

    // compare every accepted update record
    initial begin
        logic [55:0] entry;
        forever begin
            @(negedge clk);
            if (rst_n && upd_valid && upd_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: update record with no pending command in test %s",
                             cur_test);
                    abort_run();
                end else begin
                    entry = exp_q.pop_front();
                    check_value("upd_opcode", 32'(entry[55:48]), 32'(upd_opcode));
                    check_value("brightness", 32'(entry[47:32]), 32'(brightness));
                    check_value("pixel_format", 32'(entry[31:24]), 32'(pixel_format));
                    check_value("window", 32'(entry[23:0]), 32'(window));
                end
            end
        end
    end

    // panel side, random stalls in back-pressure mode
    initial begin
        forever begin
            @(posedge clk);
            if (bp_mode) begin
                upd_ready <= 1'($urandom_range(1));
            end else begin
                upd_ready <= 1'b1;
            end
        end
    end

    // budget grows with each byte list that is built
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 1000 + 20 * total_bytes) begin
                $display("ERROR: run hung in test %s after %0d cycles", cur_test, cycles);
                abort_run();
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcs_byte_fifo.sv
// Input byte FIFO
`timescale 1ns/1ps
`default_nettype none

module dcs_byte_fifo #(
    parameter int DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_ptr_nxt;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign in_ready   = (count != DEPTH[AW:0]);
    assign out_valid  = (count != '0);
    assign wr_en      = in_valid && in_ready;
    assign rd_en      = out_valid && out_ready;
    assign rd_ptr_nxt = rd_ptr + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr_nxt;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // out_data mirrors the head entry; bypass on write into empty
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (count > 1) begin
                out_data <= mem[rd_ptr_nxt];
            end else if (wr_en) begin
                out_data <= in_data;
            end
        end else if (wr_en && count == '0) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcs_cmd_if.sv
// Parsed command channel
`timescale 1ns/1ps
`default_nettype none

interface dcs_cmd_if;

    logic                   valid;
    logic                   ready;
    dcs_pkg::dcs_opcode_e   opcode;
    dcs_pkg::dcs_params_t   params;
    dcs_pkg::param_count_t  count;

    // parser side
    modport src (
        output valid,
        output opcode,
        output params,
        output count,
        input  ready
    );

    // register bank side
    modport dst (
        input  valid,
        input  opcode,
        input  params,
        input  count,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/dcs_cmd_parser.sv
// Display command parser
`timescale 1ns/1ps
`default_nettype none

module dcs_cmd_parser (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  byte_data,
    input  logic        byte_valid,
    output logic        byte_ready,
    dcs_cmd_if.src      cmd,
    output logic [7:0]  unknown_count
);

    dcs_pkg::parser_state_e state;
    dcs_pkg::param_count_t  remain;
    dcs_pkg::param_count_t  len_q;
    dcs_pkg::dcs_opcode_e   opcode_q;
    dcs_pkg::dcs_params_t   params_q;

    logic                   byte_fire;
    logic                   op_known;
    dcs_pkg::param_count_t  op_len;

    assign byte_ready = (state != dcs_pkg::EMIT);
    assign byte_fire  = byte_valid && byte_ready;

    assign cmd.valid  = (state == dcs_pkg::EMIT);
    assign cmd.opcode = opcode_q;
    assign cmd.params = params_q;
    assign cmd.count  = len_q;

    // opcode table, parameter length per opcode
    always_comb begin
        op_known = 1'b1;
        op_len   = 2'd0;
        case (byte_data)
            dcs_pkg::OP_SET_BRIGHTNESS:   op_len = 2'd2;
            dcs_pkg::OP_SET_PIXEL_FORMAT: op_len = 2'd1;
            dcs_pkg::OP_SET_WINDOW:       op_len = 2'd3;
            dcs_pkg::OP_SOFT_RESET:       op_len = 2'd0;
            default:                      op_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= dcs_pkg::IDLE;
            remain        <= '0;
            unknown_count <= '0;
        end else begin
            case (state)
                dcs_pkg::IDLE: begin
                    if (byte_fire) begin
                        if (op_known) begin
                            remain <= op_len;
                            if (op_len == 2'd0) begin
                                state <= dcs_pkg::EMIT;
                            end else begin
                                state <= dcs_pkg::PARAMS;
                            end
                        end else if (unknown_count != 8'hff) begin
                            // dropped opcode, count saturates
                            unknown_count <= unknown_count + 8'd1;
                        end
                    end
                end
                dcs_pkg::PARAMS: begin
                    if (byte_fire) begin
                        remain <= remain - 2'd1;
                        if (remain == 2'd1) begin
                            state <= dcs_pkg::EMIT;
                        end
                    end
                end
                dcs_pkg::EMIT: begin
                    if (cmd.ready) begin
                        state <= dcs_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dcs_pkg::IDLE;
                end
            endcase
        end
    end

    // command payload, captured opcode then shifted parameter bytes
    always_ff @(posedge clk) begin
        if (state == dcs_pkg::IDLE && byte_fire && op_known) begin
            opcode_q <= dcs_pkg::dcs_opcode_e'(byte_data);
            len_q    <= op_len;
            params_q <= '0;
        end else if (state == dcs_pkg::PARAMS && byte_fire) begin
            params_q <= {params_q[8*(dcs_pkg::MAX_PARAMS-1)-1:0], byte_data};
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcs_pkg.sv
// Display command shared types
`default_nettype none

package dcs_pkg;

    // longest parameter list in the opcode table
    localparam int MAX_PARAMS = 3;

    // supported command opcodes
    typedef enum logic [7:0] {
        OP_SET_BRIGHTNESS   = 8'h01,
        OP_SET_PIXEL_FORMAT = 8'h02,
        OP_SET_WINDOW       = 8'h03,
        OP_SOFT_RESET       = 8'h04
    } dcs_opcode_e;

    // parser FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        PARAMS = 2'd1,
        EMIT   = 2'd2
    } parser_state_e;

    // collected parameter bytes, right aligned, first byte most significant
    typedef logic [8*MAX_PARAMS-1:0] dcs_params_t;

    // number of parameter bytes of one command
    typedef logic [1:0] param_count_t;

endpackage

`default_nettype wire

//--- verilog/dcs_reg_bank.sv
// Panel configuration registers
`timescale 1ns/1ps
`default_nettype none

module dcs_reg_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    dcs_cmd_if.dst                cmd,
    output logic                  upd_valid,
    input  logic                  upd_ready,
    output dcs_pkg::dcs_opcode_e  upd_opcode,
    output logic [15:0]           brightness,
    output logic [7:0]            pixel_format,
    output logic [23:0]           window
);

    logic                  cmd_fire;
    dcs_pkg::dcs_params_t  param_mask;
    dcs_pkg::dcs_params_t  params_used;

    // stall while an update record waits for the panel
    assign cmd.ready = !upd_valid || upd_ready;
    assign cmd_fire  = cmd.valid && cmd.ready;

    // only the bytes the command carried
    assign param_mask  = ~({$bits(dcs_pkg::dcs_params_t){1'b1}} << (8 * cmd.count));
    assign params_used = cmd.params & param_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brightness   <= '0;
            pixel_format <= '0;
            window       <= '0;
        end else if (cmd_fire) begin
            case (cmd.opcode)
                dcs_pkg::OP_SET_BRIGHTNESS: begin
                    brightness <= params_used[15:0];
                end
                dcs_pkg::OP_SET_PIXEL_FORMAT: begin
                    pixel_format <= params_used[7:0];
                end
                dcs_pkg::OP_SET_WINDOW: begin
                    window <= params_used;
                end
                dcs_pkg::OP_SOFT_RESET: begin
                    brightness   <= '0;
                    pixel_format <= '0;
                    window       <= '0;
                end
                default: begin
                    brightness <= brightness;
                end
            endcase
        end
    end

    // update record held until the panel takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_valid <= 1'b0;
        end else if (cmd_fire) begin
            upd_valid <= 1'b1;
        end else if (upd_ready) begin
            upd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            upd_opcode <= cmd.opcode;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcs_subsystem_top.sv
// Display command subsystem
`timescale 1ns/1ps
`default_nettype none

module dcs_subsystem_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    output logic                  upd_valid,
    input  logic                  upd_ready,
    output dcs_pkg::dcs_opcode_e  upd_opcode,
    output logic [15:0]           brightness,
    output logic [7:0]            pixel_format,
    output logic [23:0]           window,
    output logic [7:0]            unknown_count
);

    logic [7:0] fifo_data;
    logic       fifo_valid;
    logic       fifo_ready;

    dcs_cmd_if cmd_if ();

    dcs_byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (rx_data),
        .in_valid  (rx_valid),
        .in_ready  (rx_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    dcs_cmd_parser u_parser (
        .clk           (clk),
        .rst_n         (rst_n),
        .byte_data     (fifo_data),
        .byte_valid    (fifo_valid),
        .byte_ready    (fifo_ready),
        .cmd           (cmd_if.src),
        .unknown_count (unknown_count)
    );

    dcs_reg_bank u_reg_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd_if.dst),
        .upd_valid    (upd_valid),
        .upd_ready    (upd_ready),
        .upd_opcode   (upd_opcode),
        .brightness   (brightness),
        .pixel_format (pixel_format),
        .window       (window)
    );

endmodule

`default_nettype wire
